//--- rotary_pkg.sv
// Shared constants and types; NUM_ENC must stay at 4 or below so flags and directions fit STATUS
package rotary_pkg;

  //////////////////////////////////////////////////
  // Sizing and timing
  //////////////////////////////////////////////////

  // Number of knobs served by one hub
  localparam int NUM_ENC         = 4;
  // Flip-flops per pin before the debounce counter
  localparam int SYNC_STAGES     = 2;
  // Equal samples needed before a new pin level is taken
  localparam int DEBOUNCE_CYCLES = 4;
  // Width of the debounce counter, large enough to hold DEBOUNCE_CYCLES
  localparam int DEB_CNT_W       = $clog2(DEBOUNCE_CYCLES + 1);
  // Bits needed to select one channel
  localparam int ENC_IDX_W       = (NUM_ENC > 1) ? $clog2(NUM_ENC) : 1;
  // Signed position counter width
  localparam int COUNT_W         = 16;

  //////////////////////////////////////////////////
  // APB port and register map
  //////////////////////////////////////////////////

  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  // Channel i sits at COUNT_BASE + 4*i, one word per channel
  localparam logic [ADDR_W-1:0] COUNT_BASE     = 8'h00;
  localparam logic [ADDR_W-1:0] STATUS_ADDR    = 8'h10;
  localparam logic [ADDR_W-1:0] EVENT_CLR_ADDR = 8'h14;

  // One A/B pin pair; both high is the detent position
  typedef struct packed {
    logic a;
    logic b;
  } enc_pins_t;

  // One step from a decoder, dir is 1 for a clockwise step
  typedef struct packed {
    logic valid;
    logic dir;
  } enc_event_t;

  // Master side of the APB bus
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  // Slave side; pready is tied high and not carried
  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

endpackage

//--- pin_sync.sv
// Pins are asynchronous; a level must be stable DEBOUNCE_CYCLES samples after sync to pass
module pin_sync import rotary_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  enc_pins_t pins       [NUM_ENC],
  output enc_pins_t clean_pins [NUM_ENC]
);

  //////////////////////////////////////////////////
  // Per channel, per pin synchronizer and filter
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < NUM_ENC; ch++) begin : g_chan
    logic [1:0] raw;
    logic [1:0] clean_q;

    // Bit 1 is pin a and bit 0 is pin b, matching the struct layout
    assign raw            = pins[ch];
    assign clean_pins[ch] = clean_q;

    for (genvar pb = 0; pb < 2; pb++) begin : g_pin
      logic [SYNC_STAGES-1:0] sync_q;
      logic [DEB_CNT_W-1:0]   stable_cnt;
      logic                   synced;

      // The last stage of the chain is the metastability-safe sample
      assign synced = sync_q[SYNC_STAGES-1];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          // Everything starts at the detent level so no false edge follows reset
          sync_q      <= '1;
          stable_cnt  <= '0;
          clean_q[pb] <= 1'b1;
        end else begin
          if (SYNC_STAGES > 1) begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], raw[pb]};
          end else begin
            sync_q <= raw[pb];
          end

          if (synced == clean_q[pb]) begin
            // Any sample that agrees with the output restarts the count
            stable_cnt <= '0;
          end else if (stable_cnt == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
            // This is the last differing sample needed, so take the new level
            clean_q[pb] <= synced;
            stable_cnt  <= '0;
          end else begin
            stable_cnt <= stable_cnt + 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- rotary_encoder_fsm.sv
// Expects debounced levels; a step counts only after the full four-phase cycle back to detent
module rotary_encoder_fsm import rotary_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  enc_pins_t  pins,
  output enc_event_t enc_event
);

  // Rn follows a clockwise turn, Ln a counter-clockwise one
  typedef enum logic [3:0] {
    IDLE_S,
    R1_S,
    R2_S,
    R3_S,
    RIGHT_S,
    L1_S,
    L2_S,
    L3_S,
    LEFT_S
  } state_t;

  state_t state_q;

  //////////////////////////////////////////////////
  // Decoder state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q         <= IDLE_S;
      enc_event.valid <= 1'b0;
      enc_event.dir   <= 1'b0;
    end else begin
      // A step lasts exactly one cycle
      enc_event.valid <= 1'b0;

      case (state_q)
        IDLE_S: begin
          // The pin that falls first tells the direction
          if (!pins.b) begin
            state_q <= R1_S;
          end else if (!pins.a) begin
            state_q <= L1_S;
          end
        end

        // Clockwise: b low, a low, b high, a high
        R1_S: begin
          if (pins.b) begin
            // b came back before a fell, so the knob never left detent
            state_q <= IDLE_S;
          end else if (!pins.a) begin
            state_q <= R2_S;
          end
        end

        R2_S: begin
          if (pins.a) begin
            state_q <= R1_S;
          end else if (pins.b) begin
            state_q <= R3_S;
          end
        end

        R3_S: begin
          if (!pins.b) begin
            state_q <= R2_S;
          end else if (pins.a) begin
            state_q <= RIGHT_S;
          end
        end

        RIGHT_S: begin
          enc_event.valid <= 1'b1;
          enc_event.dir   <= 1'b1;
          state_q         <= IDLE_S;
        end

        // Counter-clockwise mirrors the above with a and b swapped
        L1_S: begin
          if (pins.a) begin
            state_q <= IDLE_S;
          end else if (!pins.b) begin
            state_q <= L2_S;
          end
        end

        L2_S: begin
          if (pins.b) begin
            state_q <= L1_S;
          end else if (pins.a) begin
            state_q <= L3_S;
          end
        end

        L3_S: begin
          if (!pins.a) begin
            state_q <= L2_S;
          end else if (pins.b) begin
            state_q <= LEFT_S;
          end
        end

        LEFT_S: begin
          enc_event.valid <= 1'b1;
          enc_event.dir   <= 1'b0;
          state_q         <= IDLE_S;
        end

        default: begin
          // Unused encodings recover to detent
          state_q <= IDLE_S;
        end
      endcase
    end
  end

endmodule

//--- encoder_apb_regs.sv
// No wait states; pslverr on unmapped, unaligned or STATUS writes; COUNT write beats a same-cycle step
module encoder_apb_regs import rotary_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  enc_event_t events [NUM_ENC],
  input  apb_req_t   apb_req,
  output apb_rsp_t   apb_rsp,
  output logic       irq
);

  logic signed [COUNT_W-1:0] count_q [NUM_ENC];
  logic [NUM_ENC-1:0]        dir_q;
  logic [NUM_ENC-1:0]        flag_q;

  logic                 access;
  logic                 wr_en;
  logic                 rd_en;
  logic [ADDR_W-1:0]    count_off;
  logic [ENC_IDX_W-1:0] count_idx;
  logic                 count_hit;
  logic                 status_hit;
  logic                 clr_hit;
  logic                 mapped;
  logic [NUM_ENC-1:0]   count_wr;
  logic [NUM_ENC-1:0]   flag_clr;
  logic [DATA_W-1:0]    rd_word;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  // Every transfer finishes in its access phase
  assign access = apb_req.psel && apb_req.penable;
  assign wr_en  = access && apb_req.pwrite;
  assign rd_en  = access && !apb_req.pwrite;

  // An address below COUNT_BASE wraps to a large offset and misses the window
  assign count_off = apb_req.paddr - COUNT_BASE;
  assign count_idx = count_off[ENC_IDX_W+1:2];
  assign count_hit = (count_off < ADDR_W'(4 * NUM_ENC)) && (count_off[1:0] == 2'b00);

  assign status_hit = (apb_req.paddr == STATUS_ADDR);
  assign clr_hit    = (apb_req.paddr == EVENT_CLR_ADDR);
  assign mapped     = count_hit || status_hit || clr_hit;

  // Strobes per channel
  always_comb begin
    for (int i = 0; i < NUM_ENC; i++) begin
      count_wr[i] = wr_en && count_hit && (count_idx == ENC_IDX_W'(i));
      // Flag i is cleared by bit NUM_ENC+i, the same position it has in STATUS
      flag_clr[i] = wr_en && clr_hit && apb_req.pwdata[NUM_ENC + i];
    end
  end

  //////////////////////////////////////////////////
  // Counters, direction bits and sticky flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ENC; i++) begin
        count_q[i] <= '0;
      end
      dir_q  <= '0;
      flag_q <= '0;
    end else begin
      for (int i = 0; i < NUM_ENC; i++) begin
        if (count_wr[i]) begin
          // Software load takes priority over a step in the same cycle
          count_q[i] <= apb_req.pwdata[COUNT_W-1:0];
        end else if (events[i].valid) begin
          // Both directions wrap silently at COUNT_W bits
          if (events[i].dir) begin
            count_q[i] <= count_q[i] + 1'b1;
          end else begin
            count_q[i] <= count_q[i] - 1'b1;
          end
        end

        if (events[i].valid) begin
          dir_q[i]  <= events[i].dir;
          // A new step wins over a clear so no event is lost
          flag_q[i] <= 1'b1;
        end else if (flag_clr[i]) begin
          flag_q[i] <= 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Read mux and response
  //////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    if (count_hit) begin
      // Sign-extend so software sees a plain signed 32-bit value
      rd_word = {{(DATA_W - COUNT_W){count_q[count_idx][COUNT_W-1]}}, count_q[count_idx]};
    end else if (status_hit) begin
      rd_word = DATA_W'({flag_q, dir_q});
    end
    // EVENT_CLR and unmapped addresses read as zero
  end

  always_comb begin
    apb_rsp.prdata  = rd_en ? rd_word : '0;
    // STATUS is read-only, so a write there is an error too
    apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && status_hit));
  end

  // Level interrupt, held while any flag waits to be cleared
  assign irq = |flag_q;

endmodule

//--- encoder_hub.sv
// Top level; pins may be fully asynchronous, APB runs on clk with no wait states
module encoder_hub import rotary_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  enc_pins_t pins [NUM_ENC],
  input  apb_req_t  apb_req,
  output apb_rsp_t  apb_rsp,
  output logic      irq
);

  // Debounced pin levels, one pair per knob
  enc_pins_t  clean_pins [NUM_ENC];
  // One-cycle steps from the decoders
  enc_event_t events     [NUM_ENC];

  // Synchronizer and debounce for all pins at once
  pin_sync i_pin_sync (
    .clk        (clk),
    .rst_n      (rst_n),
    .pins       (pins),
    .clean_pins (clean_pins)
  );

  //////////////////////////////////////////////////
  // One decoder per channel
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < NUM_ENC; ch++) begin : g_dec
    rotary_encoder_fsm i_rotary_encoder_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .pins      (clean_pins[ch]),
      .enc_event (events[ch])
    );
  end

  // Counters, flags and the APB slave
  encoder_apb_regs i_encoder_apb_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .events  (events),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .irq     (irq)
  );

endmodule

//--- encoder_hub_properties.sv
// Bound into encoder_hub; observes the internal step events and the APB port, never drives them
module encoder_hub_properties import rotary_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input enc_event_t events [NUM_ENC],
  input apb_req_t   apb_req,
  input apb_rsp_t   apb_rsp,
  input logic       irq
);
  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // Step events
  //////////////////////////////////////////////////

  // A decoder step is a single-cycle pulse
  for (genvar ch = 0; ch < NUM_ENC; ch++) begin : g_step
    assert property (@(posedge clk) disable iff (!rst_n)
                     events[ch].valid |=> !events[ch].valid)
      else $error("Decoder %0d held its step valid for two cycles", ch);
  end

  //////////////////////////////////////////////////
  // APB response and interrupt
  //////////////////////////////////////////////////

  // An error response belongs to an access phase only
  assert property (@(posedge clk) disable iff (!rst_n)
                   apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
    else $error("pslverr was high outside an APB access phase");

  // Nothing is flagged yet when reset lets go
  assert property (@(posedge clk) $rose(rst_n) |-> !irq)
    else $error("irq was high in the first cycle after reset");

endmodule

bind encoder_hub encoder_hub_properties i_encoder_hub_properties (
  .clk     (clk),
  .rst_n   (rst_n),
  .events  (events),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .irq     (irq)
);

//--- tb_encoder_hub.sv
// Reads encoder_trace.txt from the directory the run starts in; expects NUM_ENC of 4 in P records
module tb_encoder_hub import rotary_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // Longest pin hold a trace record may ask for
  localparam int HOLD_LIMIT  = 1000;
  // Falling edges allowed for the APB response to settle in its access phase
  localparam int APB_TIMEOUT = 4;
  // Upper bound on trace lines read
  localparam int LINE_LIMIT  = 1000;

  logic      clk;
  logic      rst_n;
  enc_pins_t pins [NUM_ENC];
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;
  logic      irq;

  int    errors;
  bit    aborted;
  string test_name;

  encoder_hub i_encoder_hub (
    .clk     (clk),
    .rst_n   (rst_n),
    .pins    (pins),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .irq     (irq)
  );

  // 20 ns clock
  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Reports a fault in plain words and stops reading further records
  task automatic abort_run(input string why);
    $display("%s: %s", test_name, why);
    aborted = 1'b1;
  endtask

  task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %s %s: expected 0x%08h actual 0x%08h", test_name, what, expected, actual);
    end
  endtask

  // Bit pair 2*i+1:2*i is a and b of channel i
  task automatic hold_pins(input logic [2*NUM_ENC-1:0] lvl, input int hold);
    int n;
    n = 0;
    @(posedge clk);
    #2;
    for (int i = 0; i < NUM_ENC; i++) begin
      pins[i] = lvl[2*i +: 2];
    end
    while (n < hold && n < HOLD_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (n < hold) begin
      abort_run("a pin hold ran past the cycle limit");
    end
  endtask

  // Setup phase, then access phase; the slave answers within the access phase
  task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
    int n;
    bit settled;
    n       = 0;
    settled = 1'b0;
    @(posedge clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    // The response is combinational, so it must be known by a falling edge of the access phase
    while (!settled && n < APB_TIMEOUT) begin
      @(negedge clk);
      n++;
      settled = !$isunknown(apb_rsp);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    // The rising edge that ends the access phase completes the transfer
    @(posedge clk);
    #2;
    apb_req = '0;
    if (!settled) begin
      abort_run("the APB response stayed unknown through its access phase");
    end
  endtask

  task automatic run_record(input string line);
    string             name;
    logic [3:0]        p0, p1, p2, p3;
    logic [3:0]        flag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] rdata;
    logic              err;
    int                hold;
    int                fields;
    int                want;
    fields = 0;
    want   = 0;
    case (line[0])
      "A": begin
        want      = 1;
        fields    = $sscanf(line, "A %s", name);
        test_name = name;
      end
      "P": begin
        want   = 5;
        fields = $sscanf(line, "P %h %h %h %h %d", p0, p1, p2, p3, hold);
        hold_pins({p3[1:0], p2[1:0], p1[1:0], p0[1:0]}, hold);
      end
      "W": begin
        want   = 3;
        fields = $sscanf(line, "W %h %h %h", addr, data, flag);
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value($sformatf("write 0x%02h pslverr", addr), DATA_W'(flag), DATA_W'(err));
      end
      "R": begin
        want   = 3;
        fields = $sscanf(line, "R %h %h %h", addr, data, flag);
        apb_transfer(1'b0, addr, '0, rdata, err);
        check_value($sformatf("read 0x%02h data", addr), data, rdata);
        check_value($sformatf("read 0x%02h pslverr", addr), DATA_W'(flag), DATA_W'(err));
      end
      "I": begin
        want   = 1;
        fields = $sscanf(line, "I %h", flag);
        @(negedge clk);
        check_value("irq", DATA_W'(flag), DATA_W'(irq));
      end
      8'h00, 8'h0A, 8'h0D, " ", "#": begin
        // Blank lines and comments carry nothing
      end
      default: begin
        abort_run($sformatf("the trace holds an unknown record kind: %s", line));
      end
    endcase
    if (fields != want) begin
      abort_run($sformatf("a trace record has missing fields: %s", line));
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int    fd;
    int    lines;
    string line;
    clk       = 1'b0;
    rst_n     = 1'b0;
    apb_req   = '0;
    errors    = 0;
    aborted   = 1'b0;
    lines     = 0;
    test_name = "setup";
    // Knobs rest at detent during reset
    for (int i = 0; i < NUM_ENC; i++) begin
      pins[i] = '1;
    end
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
    end
    #2;
    rst_n = 1'b1;

    fd = $fopen("encoder_trace.txt", "r");
    if (fd == 0) begin
      abort_run("encoder_trace.txt could not be opened");
    end else begin
      while (!aborted && !$feof(fd) && lines < LINE_LIMIT) begin
        if ($fgets(line, fd) > 0) begin
          run_record(line);
        end
        lines++;
      end
      if (!aborted && !$feof(fd)) begin
        abort_run("the trace file is longer than the line limit");
      end
      $fclose(fd);
    end

    $display("Errors: %0d failed checks, run %s", errors, aborted ? "aborted" : "complete");
    if (errors == 0 && !aborted) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- src.f
rotary_pkg.sv
pin_sync.sv
rotary_encoder_fsm.sv
encoder_apb_regs.sv
encoder_hub.sv
encoder_hub_properties.sv
tb_encoder_hub.sv

//--- Makefile
TOP = tb_encoder_hub
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

# The run must start in the project root so the trace file is found
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Test failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- encoder_trace.txt
# P ch0 ch1 ch2 ch3 hold: pin pairs in hex (bit 1 is a, bit 0 is b), hold in decimal cycles
# W addr data pslverr / R addr data pslverr / I irq / A group name; values in hex
A reset_values
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 0C 00000000 0
R 10 00000000 0
I 0
A full_steps
P 2 3 1 3 12
P 0 3 0 3 12
P 1 3 2 3 12
P 3 3 3 3 12
P 2 3 1 3 12
P 0 3 0 3 12
P 1 3 2 3 12
P 3 3 3 3 12
P 2 3 3 3 12
P 0 3 3 3 12
P 1 3 3 3 12
P 3 3 3 3 12
R 00 00000003 0
R 08 FFFFFFFE 0
R 10 00000051 0
I 1
A reversal_and_glitch
P 3 2 3 0 1
P 3 2 3 3 12
P 3 0 3 3 12
P 3 2 3 3 12
P 3 3 3 3 12
R 04 00000000 0
R 0C 00000000 0
A count_load_wrap
W 04 00008000 0
R 04 FFFF8000 0
P 3 1 3 3 12
P 3 0 3 3 12
P 3 2 3 3 12
P 3 3 3 3 12
R 04 00007FFF 0
A event_clear
W 14 00000050 0
R 10 00000021 0
I 1
W 14 00000020 0
R 10 00000001 0
I 0
A bus_errors
R 20 00000000 1
W 10 000000FF 1
R 10 00000001 0
R 00 00000003 0
